// File: logic/udp_echo_cfg.svh
`ifndef UDP_ECHO_CFG_SVH
`define UDP_ECHO_CFG_SVH

// Station addresses
`define LOCAL_MAC 48'h02_00_00_00_00_00

// 192.168.11.128
`define LOCAL_IP 32'hc0_a8_0b_80

// UDP port that gets echoed
`define ECHO_PORT 16'd1234

`define REPLY_TTL 8'd64

// Ethernet 14 + IPv4 20 + UDP 8
`define HDR_BYTES 42

// Payload buffer in bytes, power of two
`define FIFO_DEPTH 2048

`endif

// File: logic/udp_echo_pkg.sv
package udp_echo_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] len16_t;
    typedef logic [7:0]  byte_t;

    // Fields kept from an inbound Ethernet/IPv4/UDP header
    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        len16_t      eth_type;
        logic [3:0]  ihl;
        len16_t      ip_length;
        logic [7:0]  protocol;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        len16_t      udp_length;
    } rx_hdr_t;

    // Parser FSM
    typedef enum logic [1:0] {
        PS_HDR,
        PS_PAYLOAD,
        PS_DISCARD
    } parse_state_t;

    // Reply builder FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEADER,
        TX_PAYLOAD
    } tx_state_t;

endpackage

// File: logic/frame_parser.sv
`timescale 1ns/1ns
`include "udp_echo_cfg.svh"

module frame_parser import udp_echo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  byte_t   in_data,
    input  logic    in_valid,
    input  logic    in_last,
    output logic    in_ready,
    output rx_hdr_t hdr,
    output logic    hdr_valid,
    input  logic    hdr_ready,
    output byte_t   pay_data,
    output logic    pay_valid,
    output logic    pay_last,
    input  logic    pay_ready
);

    localparam logic [5:0] LAST_IDX = 6'(`HDR_BYTES - 1);

    parse_state_t state;
    logic [5:0]   idx;
    int           pos;

    assign pos = int'(idx);

    always_comb begin
        case (state)
            PS_HDR:     in_ready = 1'b1;
            // Payload waits until the header has been taken
            PS_PAYLOAD: in_ready = !hdr_valid && pay_ready;
            default:    in_ready = 1'b0;
        endcase
    end

    assign pay_data  = in_data;
    assign pay_last  = in_last;
    assign pay_valid = (state == PS_PAYLOAD) && !hdr_valid && in_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= PS_HDR;
            idx       <= '0;
            hdr_valid <= 1'b0;
        end else begin
            if (hdr_valid && hdr_ready) begin
                hdr_valid <= 1'b0;
            end
            case (state)
                PS_HDR: begin
                    if (in_valid) begin
                        // Runt, or a header with no payload behind it
                        if (in_last) begin
                            state <= PS_DISCARD;
                        end else if (idx == LAST_IDX) begin
                            state     <= PS_PAYLOAD;
                            hdr_valid <= 1'b1;
                            idx       <= '0;
                        end else begin
                            idx <= idx + 6'd1;
                        end
                    end
                end
                PS_PAYLOAD: begin
                    if (in_valid && in_ready && in_last) begin
                        state <= PS_HDR;
                    end
                end
                default: begin
                    state <= PS_HDR;
                    idx   <= '0;
                end
            endcase
        end
    end

    // Field capture by byte position
    always_ff @(posedge clk) begin
        if (state == PS_HDR && in_valid) begin
            if (pos < 6) begin
                hdr.dest_mac[8*(5-pos) +: 8] <= in_data;
            end else if (pos < 12) begin
                hdr.src_mac[8*(11-pos) +: 8] <= in_data;
            end else if (pos < 14) begin
                hdr.eth_type[8*(13-pos) +: 8] <= in_data;
            end else if (pos == 14) begin
                hdr.ihl <= in_data[3:0];
            end else if (pos == 16 || pos == 17) begin
                hdr.ip_length[8*(17-pos) +: 8] <= in_data;
            end else if (pos == 23) begin
                hdr.protocol <= in_data;
            end else if (pos >= 26 && pos < 30) begin
                hdr.src_ip[8*(29-pos) +: 8] <= in_data;
            end else if (pos >= 30 && pos < 34) begin
                hdr.dst_ip[8*(33-pos) +: 8] <= in_data;
            end else if (pos == 34 || pos == 35) begin
                hdr.src_port[8*(35-pos) +: 8] <= in_data;
            end else if (pos == 36 || pos == 37) begin
                hdr.dst_port[8*(37-pos) +: 8] <= in_data;
            end else if (pos == 38 || pos == 39) begin
                hdr.udp_length[8*(39-pos) +: 8] <= in_data;
            end
        end
    end

endmodule

// File: logic/echo_filter.sv
`timescale 1ns/1ns
`include "udp_echo_cfg.svh"

module echo_filter import udp_echo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  rx_hdr_t hdr_in,
    input  logic    hdr_in_valid,
    output logic    hdr_in_ready,
    input  byte_t   pay_in_data,
    input  logic    pay_in_valid,
    input  logic    pay_in_last,
    output logic    pay_in_ready,
    output rx_hdr_t hdr_out,
    output logic    hdr_out_valid,
    input  logic    hdr_out_ready,
    output byte_t   pay_out_data,
    output logic    pay_out_valid,
    output logic    pay_out_last,
    input  logic    pay_out_ready
);

    logic match;
    logic accept_q;
    logic drop_q;

    assign match = (hdr_in.eth_type == 16'h0800) &&
                   (hdr_in.ihl == 4'd5) &&
                   (hdr_in.protocol == 8'd17) &&
                   (hdr_in.dst_ip == `LOCAL_IP) &&
                   (hdr_in.dst_port == `ECHO_PORT);

    assign hdr_out       = hdr_in;
    assign hdr_out_valid = hdr_in_valid && match;
    // Rejected headers are swallowed right away
    assign hdr_in_ready  = match ? hdr_out_ready : 1'b1;

    assign pay_out_data  = pay_in_data;
    assign pay_out_last  = pay_in_last;
    assign pay_out_valid = pay_in_valid && accept_q;
    assign pay_in_ready  = (accept_q && pay_out_ready) || drop_q;

    // Decision held for the whole payload of the frame
    always_ff @(posedge clk) begin
        if (rst) begin
            accept_q <= 1'b0;
            drop_q   <= 1'b0;
        end else if (hdr_in_valid && hdr_in_ready) begin
            accept_q <= match;
            drop_q   <= !match;
        end else if (pay_in_valid && pay_in_ready && pay_in_last) begin
            accept_q <= 1'b0;
            drop_q   <= 1'b0;
        end
    end

endmodule

// File: logic/payload_fifo.sv
`timescale 1ns/1ns
`include "udp_echo_cfg.svh"

module payload_fifo import udp_echo_pkg::*; #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  rst,
    input  byte_t in_data,
    input  logic  in_valid,
    input  logic  in_last,
    output logic  in_ready,
    output byte_t out_data,
    output logic  out_valid,
    output logic  out_last,
    input  logic  out_ready
);

    localparam int AW = $clog2(DEPTH);

    // Entry is {last, data}
    logic [8:0]  mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign {out_last, out_data} = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (in_valid && !full) begin
            mem[wr_ptr[AW-1:0]] <= {in_last, in_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_ready && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: logic/reply_builder.sv
`timescale 1ns/1ns
`include "udp_echo_cfg.svh"

module reply_builder import udp_echo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  rx_hdr_t hdr,
    input  logic    hdr_valid,
    output logic    hdr_ready,
    input  byte_t   pay_data,
    input  logic    pay_valid,
    input  logic    pay_last,
    output logic    pay_ready,
    output byte_t   out_data,
    output logic    out_valid,
    output logic    out_last,
    input  logic    out_ready
);

    localparam logic [5:0] LAST_IDX = 6'(`HDR_BYTES - 1);

    tx_state_t                  state;
    logic [5:0]                 idx;
    byte_t [`HDR_BYTES-1:0]     tx_hdr_q;
    byte_t [`HDR_BYTES-1:0]     tx_hdr_d;
    logic [19:0]                sum;
    logic [16:0]                fold;
    len16_t                     csum;

    // IP header words, checksum slot taken as zero
    assign sum = 20'h04500 +
                 20'(hdr.ip_length) +
                 20'({`REPLY_TTL, 8'd17}) +
                 20'(`LOCAL_IP >> 16) +
                 20'(`LOCAL_IP & 32'h0000_ffff) +
                 20'(hdr.src_ip[31:16]) +
                 20'(hdr.src_ip[15:0]);

    always_comb begin
        fold = 17'(sum[15:0]) + 17'(sum[19:16]);
        fold = 17'(fold[15:0]) + 17'(fold[16]);
        csum = ~fold[15:0];
    end

    // Byte 0 of the wire sits in the top slot
    assign tx_hdr_d = {
        hdr.src_mac, `LOCAL_MAC, 16'h0800,
        8'h45, 8'h00, hdr.ip_length,
        16'h0000, 16'h0000,
        `REPLY_TTL, 8'd17, csum,
        `LOCAL_IP, hdr.src_ip,
        hdr.dst_port, hdr.src_port, hdr.udp_length, 16'h0000
    };

    assign hdr_ready = (state == TX_IDLE);

    always_comb begin
        out_data  = 8'h00;
        out_valid = 1'b0;
        out_last  = 1'b0;
        pay_ready = 1'b0;
        case (state)
            TX_HEADER: begin
                out_data  = tx_hdr_q[LAST_IDX - idx];
                out_valid = 1'b1;
            end
            TX_PAYLOAD: begin
                out_data  = pay_data;
                out_valid = pay_valid;
                // An empty FIFO still shows a stale last flag
                out_last  = pay_valid && pay_last;
                pay_ready = out_ready;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (hdr_valid && hdr_ready) begin
            tx_hdr_q <= tx_hdr_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TX_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (hdr_valid) begin
                        state <= TX_HEADER;
                        idx   <= '0;
                    end
                end
                TX_HEADER: begin
                    if (out_ready) begin
                        if (idx == LAST_IDX) begin
                            state <= TX_PAYLOAD;
                        end
                        idx <= idx + 6'd1;
                    end
                end
                TX_PAYLOAD: begin
                    if (pay_valid && out_ready && pay_last) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

// File: logic/udp_echo_top.sv
`timescale 1ns/1ns

module udp_echo_top import udp_echo_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t in_data,
    input  logic  in_valid,
    input  logic  in_last,
    output logic  in_ready,
    output byte_t out_data,
    output logic  out_valid,
    output logic  out_last,
    input  logic  out_ready
);

    // Parser to filter
    rx_hdr_t p_hdr;
    logic    p_hdr_valid;
    logic    p_hdr_ready;
    byte_t   p_pay_data;
    logic    p_pay_valid;
    logic    p_pay_last;
    logic    p_pay_ready;

    // Filter to builder and FIFO
    rx_hdr_t f_hdr;
    logic    f_hdr_valid;
    logic    f_hdr_ready;
    byte_t   f_pay_data;
    logic    f_pay_valid;
    logic    f_pay_last;
    logic    f_pay_ready;

    // FIFO to builder
    byte_t   q_pay_data;
    logic    q_pay_valid;
    logic    q_pay_last;
    logic    q_pay_ready;

    frame_parser parser_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .hdr       (p_hdr),
        .hdr_valid (p_hdr_valid),
        .hdr_ready (p_hdr_ready),
        .pay_data  (p_pay_data),
        .pay_valid (p_pay_valid),
        .pay_last  (p_pay_last),
        .pay_ready (p_pay_ready)
    );

    echo_filter filter_i (
        .clk           (clk),
        .rst           (rst),
        .hdr_in        (p_hdr),
        .hdr_in_valid  (p_hdr_valid),
        .hdr_in_ready  (p_hdr_ready),
        .pay_in_data   (p_pay_data),
        .pay_in_valid  (p_pay_valid),
        .pay_in_last   (p_pay_last),
        .pay_in_ready  (p_pay_ready),
        .hdr_out       (f_hdr),
        .hdr_out_valid (f_hdr_valid),
        .hdr_out_ready (f_hdr_ready),
        .pay_out_data  (f_pay_data),
        .pay_out_valid (f_pay_valid),
        .pay_out_last  (f_pay_last),
        .pay_out_ready (f_pay_ready)
    );

    payload_fifo fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (f_pay_data),
        .in_valid  (f_pay_valid),
        .in_last   (f_pay_last),
        .in_ready  (f_pay_ready),
        .out_data  (q_pay_data),
        .out_valid (q_pay_valid),
        .out_last  (q_pay_last),
        .out_ready (q_pay_ready)
    );

    reply_builder builder_i (
        .clk       (clk),
        .rst       (rst),
        .hdr       (f_hdr),
        .hdr_valid (f_hdr_valid),
        .hdr_ready (f_hdr_ready),
        .pay_data  (q_pay_data),
        .pay_valid (q_pay_valid),
        .pay_last  (q_pay_last),
        .pay_ready (q_pay_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

// File: tb/udp_echo_checker.sv
`timescale 1ns/1ns

module udp_echo_checker import udp_echo_pkg::*; (
    input logic  clk,
    input logic  rst,
    input byte_t out_data,
    input logic  out_valid,
    input logic  out_last,
    input logic  out_ready
);

    // Byte under back-pressure stays put
    hold_a: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_data or out_valid changed while out_ready was low");

    // Reset leaves the output idle
    reset_idle_a: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    last_valid_a: assert property (@(posedge clk) disable iff (rst)
        out_last |-> out_valid)
        else $error("out_last high without out_valid");

endmodule

// File: tb/tb_udp_echo.sv
`timescale 1ns/1ns
`include "udp_echo_cfg.svh"

module tb_udp_echo import udp_echo_pkg::*; ();

    typedef byte_t byte_q_t[$];

    // Whole run is a few thousand cycles
    localparam int CYCLE_LIMIT = 20000;
    localparam int REPLY_WAIT  = 1000;

    logic  clk = 1'b0;
    logic  rst;
    byte_t in_data;
    logic  in_valid;
    logic  in_last;
    logic  in_ready;
    byte_t out_data;
    logic  out_valid;
    logic  out_last;
    logic  out_ready;
    int    cycle_count = 0;

    udp_echo_top dut_i (.*);

    bind udp_echo_top udp_echo_checker checker_i (.*);

    always #10 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout: run exceeded %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            fail_run("wrong value from the DUT");
        end
    endtask

    // Folded ones' complement sum of big-endian 16-bit words
    function automatic len16_t ones_sum(input byte_t b[$], input int start, input int words);
        logic [31:0] s;
        s = 0;
        for (int k = 0; k < words; k++) begin
            s += {16'h0, b[start + 2*k], b[start + 2*k + 1]};
        end
        while (s[31:16] != 0) begin
            s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
        end
        return s[15:0];
    endfunction

    function automatic rx_hdr_t good_hdr(input int n);
        rx_hdr_t h;
        h.dest_mac   = `LOCAL_MAC;
        h.src_mac    = 48'h00_1b_21_3a_4c_5d;
        h.eth_type   = 16'h0800;
        h.ihl        = 4'd5;
        h.ip_length  = 16'(28 + n);
        h.protocol   = 8'd17;
        h.src_ip     = 32'hc0_a8_0b_0a;
        h.dst_ip     = `LOCAL_IP;
        h.src_port   = 16'(40000 + n);
        h.dst_port   = `ECHO_PORT;
        h.udp_length = 16'(8 + n);
        return h;
    endfunction

    function automatic byte_q_t random_payload(input int n);
        byte_q_t q;
        for (int k = 0; k < n; k++) begin
            q.push_back(byte_t'($urandom));
        end
        return q;
    endfunction

    // max_len of zero sends the whole frame
    task automatic send_frame(input rx_hdr_t h, input byte_t pay[$], input int max_len);
        logic [335:0] raw;
        byte_t        bytes[$];
        int           i;
        bit           taken;
        raw = {h.dest_mac, h.src_mac, h.eth_type, 4'h4, h.ihl, 8'h00, h.ip_length,
               16'h1c46, 16'h4000, 8'h80, h.protocol, 16'hb1e6, h.src_ip, h.dst_ip,
               h.src_port, h.dst_port, h.udp_length, 16'h0000};
        for (int k = 0; k < 42; k++) begin
            bytes.push_back(raw[8*(41-k) +: 8]);
        end
        foreach (pay[k]) begin
            bytes.push_back(pay[k]);
        end
        while (max_len > 0 && bytes.size() > max_len) begin
            void'(bytes.pop_back());
        end
        i = 0;
        @(posedge clk);
        in_data  <= bytes[0];
        in_valid <= 1'b1;
        in_last  <= (bytes.size() == 1);
        while (i < bytes.size()) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            if (taken) begin
                i++;
                if (i < bytes.size()) begin
                    in_data <= bytes[i];
                    in_last <= (i == bytes.size() - 1);
                end else begin
                    in_valid <= 1'b0;
                    in_last  <= 1'b0;
                end
            end
        end
    endtask

    task automatic expect_reply(input rx_hdr_t h, input byte_t pay[$], input bit rand_ready);
        logic [335:0] rep;
        byte_t        exp[$];
        byte_t        got[$];
        int           idle;
        int           k;
        bit           done;
        rep = {h.src_mac, `LOCAL_MAC, 16'h0800, 8'h45, 8'h00, h.ip_length, 16'h0, 16'h0,
               `REPLY_TTL, 8'd17, 16'h0, `LOCAL_IP, h.src_ip,
               h.dst_port, h.src_port, h.udp_length, 16'h0};
        for (k = 0; k < 42; k++) begin
            exp.push_back(rep[8*(41-k) +: 8]);
        end
        foreach (pay[j]) begin
            exp.push_back(pay[j]);
        end
        idle = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            out_ready <= rand_ready ? 1'($urandom % 2) : 1'b1;
            @(negedge clk);
            if (out_valid && out_ready) begin
                idle = 0;
                k    = got.size();
                if (k >= exp.size()) begin
                    fail_run($sformatf("reply longer than the expected %0d bytes", exp.size()));
                end
                // Checksum bytes are covered by the header sum below
                if (k != 24 && k != 25) begin
                    check_value($sformatf("out_data[%0d]", k), out_data, exp[k]);
                end
                check_value($sformatf("out_last[%0d]", k), out_last, k == exp.size() - 1);
                got.push_back(out_data);
                done = out_last;
            end else begin
                idle++;
                if (idle > REPLY_WAIT) begin
                    fail_run($sformatf("no reply byte for %0d cycles after %0d bytes",
                                       REPLY_WAIT, got.size()));
                end
            end
        end
        check_value("ip header ones' complement sum", ones_sum(got, 14, 10), 16'hffff);
    endtask

    task automatic watch_silence(input int cycles);
        @(posedge clk);
        out_ready <= 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            if (out_valid) begin
                fail_run("output appeared for a frame that should have been dropped");
            end
        end
    endtask

    task automatic test_basic_echo();
        rx_hdr_t h;
        byte_q_t pay;
        h   = good_hdr(18);
        pay = random_payload(18);
        fork
            send_frame(h, pay, 0);
            expect_reply(h, pay, 1'b0);
        join
    endtask

    task automatic test_rejects();
        rx_hdr_t h;
        rx_hdr_t bad[4];
        byte_q_t pay;
        h   = good_hdr(20);
        pay = random_payload(20);
        foreach (bad[k]) begin
            bad[k] = h;
        end
        bad[0].dst_port = `ECHO_PORT + 16'd1;
        bad[1].eth_type = 16'h86dd;
        bad[2].protocol = 8'd6;
        bad[3].dst_ip   = `LOCAL_IP ^ 32'h1;
        fork
            begin
                foreach (bad[k]) begin
                    send_frame(bad[k], pay, 0);
                end
                send_frame(h, pay, 30);
            end
            watch_silence(400);
        join
        fork
            send_frame(h, pay, 0);
            expect_reply(h, pay, 1'b0);
        join
    endtask

    task automatic test_backpressure();
        rx_hdr_t h;
        byte_q_t pay;
        h        = good_hdr(200);
        h.src_ip = 32'hc0_a8_0b_21;
        pay      = random_payload(200);
        fork
            send_frame(h, pay, 0);
            expect_reply(h, pay, 1'b1);
        join
    endtask

    task automatic test_back_to_back();
        rx_hdr_t h[3];
        byte_q_t p[3];
        rx_hdr_t bad;
        byte_q_t bad_pay;
        for (int k = 0; k < 3; k++) begin
            h[k]        = good_hdr(25 + 11*k);
            h[k].src_ip = 32'hc0_a8_0b_10 + k;
            p[k]        = random_payload(25 + 11*k);
        end
        bad          = good_hdr(16);
        bad.dst_port = 16'd7;
        bad_pay      = random_payload(16);
        fork
            begin
                send_frame(h[0], p[0], 0);
                send_frame(bad, bad_pay, 0);
                send_frame(h[1], p[1], 0);
                send_frame(h[2], p[2], 0);
            end
            begin
                for (int k = 0; k < 3; k++) begin
                    expect_reply(h[k], p[k], 1'b0);
                end
            end
        join
    endtask

    initial begin
        void'($urandom(32'he198f987));
        rst       = 1'b1;
        in_data   = 8'h00;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // Parser idles in its header state
        check_value("in_ready", in_ready, 1'b1);
        test_basic_echo();
        test_rejects();
        test_backpressure();
        test_back_to_back();
        repeat (5) @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: sim.f
+incdir+logic
logic/udp_echo_pkg.sv
logic/frame_parser.sv
logic/echo_filter.sv
logic/payload_fifo.sv
logic/reply_builder.sv
logic/udp_echo_top.sv
tb/udp_echo_checker.sv
tb/tb_udp_echo.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_udp_echo
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
